// File: common/xpu_cfg_if.sv
// xpu configuration bundle
`timescale 1ns/10ps

interface xpu_cfg_if;

    // tsf load request, one clock wide
    logic                   tsf_load_pulse;
    xpu_pkg::tsf_t          tsf_load_val;

    // band and erp short slot from reg 4
    xpu_pkg::band_t         band;
    logic                   erp_short_slot;

    // debug xifs override from reg 9
    logic                   xifs_ovr;
    xpu_pkg::slot_t         slot_ovr;
    xpu_pkg::sifs_t         sifs_ovr;

    // cca threshold, half dB
    xpu_pkg::rssi_t         rssi_th;

    // adc mute override from reg 1
    logic                   mute_ovr;
    logic                   mute_val;

    modport regs (
        output tsf_load_pulse,
        output tsf_load_val,
        output band,
        output erp_short_slot,
        output xifs_ovr,
        output slot_ovr,
        output sifs_ovr,
        output rssi_th,
        output mute_ovr,
        output mute_val
    );

    modport tsf (
        input  tsf_load_pulse,
        input  tsf_load_val
    );

    modport status (
        input  band,
        input  erp_short_slot,
        input  xifs_ovr,
        input  slot_ovr,
        input  sifs_ovr,
        input  rssi_th,
        input  mute_ovr,
        input  mute_val
    );

endinterface

// File: common/xpu_macros.svh
// xpu register map and timing constants
`ifndef XPU_MACROS_SVH
`define XPU_MACROS_SVH

// register indices, word addressed
`define XPU_REG_ADDR_W      6
`define XPU_REG_RESET       6'd0
`define XPU_REG_MUTE        6'd1
`define XPU_REG_TSF_LO      6'd2
`define XPU_REG_TSF_HI      6'd3
`define XPU_REG_BAND        6'd4
`define XPU_REG_RSSI_TH     6'd8
`define XPU_REG_XIFS        6'd9
`define XPU_REG_BB_RF_DLY   6'd10
// read only
`define XPU_REG_TSF_RD_LO   6'd58
`define XPU_REG_TSF_RD_HI   6'd59
`define XPU_REG_VERSION     6'd63

// system clock cycles in one microsecond
`define XPU_CLK_PER_US      100

`define XPU_VERSION         32'h5e1a_0c21

// slot and sifs defaults in us
`define XPU_SLOT_24G_LONG   5'd20
`define XPU_SLOT_24G_SHORT  5'd9
`define XPU_SLOT_5G         5'd9
`define XPU_SIFS_24G        7'd10
`define XPU_SIFS_5G         7'd16

// band code for 2.4GHz
`define XPU_BAND_24G        4'd1

// single bit fields
`define XPU_BIT_TSF_LOAD    31
`define XPU_BIT_XIFS_OVR    31
`define XPU_BIT_MUTE_OVR    0
`define XPU_BIT_MUTE_VAL    31
`define XPU_BIT_RST_TXON    0
`define XPU_BIT_ERP_SHORT   24

// multi bit field offsets
`define XPU_BAND_LSB        16
`define XPU_SLOT_LSB        14
`define XPU_SIFS_LSB        7

`endif

// File: common/xpu_pkg.sv
// xpu shared types
package xpu_pkg;

    // register word as seen on the register port
    typedef logic [31:0] reg_word_t;

    // 802.11 timing synchronization function, 1us per lsb
    typedef logic [63:0] tsf_t;

    // rssi in half dB steps, may go negative
    typedef logic signed [10:0] rssi_t;

    typedef logic [3:0] band_t;
    typedef logic [7:0] channel_t;

    // slot time in us
    typedef logic [4:0] slot_t;

    // sifs time in us
    typedef logic [6:0] sifs_t;

    // baseband to rf tail length in clocks
    typedef logic [13:0] dly_t;

    // tx-on tracking
    // bb window, then rf tail until the delay runs out
    typedef enum logic [1:0] {
        TXON_IDLE    = 2'd0,
        TXON_BB      = 2'd1,
        TXON_RF_TAIL = 2'd2
    } txon_state_t;

endpackage

// File: logic/medium_status.sv
// cca, adc mute and xifs selection
`timescale 1ns/10ps
`include "xpu_macros.svh"

module medium_status (
    xpu_cfg_if.status       cfg,
    input  xpu_pkg::rssi_t  rssi_half_db_i,
    input  logic            demod_is_ongoing_i,
    input  logic            tx_rf_is_ongoing_i,
    input  logic            cts_toself_rf_is_ongoing_i,
    output logic            ch_idle_o,
    output logic            mute_adc_out_to_bb_o,
    output xpu_pkg::slot_t  slot_time_o,
    output xpu_pkg::sifs_t  sifs_time_o
);

    logic           medium_busy_own;
    logic           band_is_24g;
    xpu_pkg::slot_t slot_default;
    xpu_pkg::sifs_t sifs_default;

    // own rf activity, either real tx or cts-to-self
    assign medium_busy_own = tx_rf_is_ongoing_i | cts_toself_rf_is_ongoing_i;

    // signed compare, both sides half dB
    // idle only when quiet and nothing being demodulated or sent
    assign ch_idle_o = (rssi_half_db_i < cfg.rssi_th)
                     & ~demod_is_ongoing_i
                     & ~medium_busy_own;

    // self rx is muted while we transmit, unless forced
    assign mute_adc_out_to_bb_o = cfg.mute_ovr ? cfg.mute_val : medium_busy_own;

    assign band_is_24g = (cfg.band == `XPU_BAND_24G);

    // 802.11 erp short slot only matters on 2.4GHz
    always_comb begin
        if (band_is_24g) begin
            slot_default = cfg.erp_short_slot ? `XPU_SLOT_24G_SHORT : `XPU_SLOT_24G_LONG;
            sifs_default = `XPU_SIFS_24G;
        end else begin
            slot_default = `XPU_SLOT_5G;
            sifs_default = `XPU_SIFS_5G;
        end
    end

    // debug override from reg 9
    assign slot_time_o = cfg.xifs_ovr ? cfg.slot_ovr : slot_default;
    assign sifs_time_o = cfg.xifs_ovr ? cfg.sifs_ovr : sifs_default;

endmodule

// File: logic/xpu_reg_bank.sv
// xpu register bank
`timescale 1ns/10ps
`include "xpu_macros.svh"

module xpu_reg_bank (
    input  logic                        s00_axi_aclk_i,
    input  logic                        reset_i,
    input  logic                        reg_wr_en_i,
    input  logic [`XPU_REG_ADDR_W-1:0]  reg_addr_i,
    input  xpu_pkg::reg_word_t          reg_wdata_i,
    input  logic [`XPU_REG_ADDR_W-1:0]  reg_rd_addr_i,
    input  xpu_pkg::tsf_t               tsf_runtime_val_i,
    output xpu_pkg::reg_word_t          reg_rdata_o,
    xpu_cfg_if.regs                     cfg,
    output logic                        txon_soft_rst_o,
    output xpu_pkg::dly_t               bb_rf_delay_top_o,
    output xpu_pkg::band_t              band_o,
    output xpu_pkg::channel_t           channel_o
);

    // soft resets
    xpu_pkg::reg_word_t slv_reg0;
    // mute override
    xpu_pkg::reg_word_t slv_reg1;
    // tsf load value low
    xpu_pkg::reg_word_t slv_reg2;
    // tsf load value high, msb rising edge loads
    xpu_pkg::reg_word_t slv_reg3;
    // erp short slot, band, channel
    xpu_pkg::reg_word_t slv_reg4;
    // cca rssi threshold
    xpu_pkg::reg_word_t slv_reg8;
    // xifs override word
    xpu_pkg::reg_word_t slv_reg9;
    // bb to rf delay in clocks
    xpu_pkg::reg_word_t slv_reg10;

    logic tsf_load_ctl_d;
    logic tsf_load_pulse;

    // write decode, new value visible the cycle after the strobe
    always_ff @(posedge s00_axi_aclk_i) begin
        if (reset_i) begin
            slv_reg0  <= '0;
            slv_reg1  <= '0;
            slv_reg2  <= '0;
            slv_reg3  <= '0;
            slv_reg4  <= '0;
            slv_reg8  <= '0;
            slv_reg9  <= '0;
            slv_reg10 <= '0;
        end else if (reg_wr_en_i) begin
            case (reg_addr_i)
                `XPU_REG_RESET:     slv_reg0  <= reg_wdata_i;
                `XPU_REG_MUTE:      slv_reg1  <= reg_wdata_i;
                `XPU_REG_TSF_LO:    slv_reg2  <= reg_wdata_i;
                `XPU_REG_TSF_HI:    slv_reg3  <= reg_wdata_i;
                `XPU_REG_BAND:      slv_reg4  <= reg_wdata_i;
                `XPU_REG_RSSI_TH:   slv_reg8  <= reg_wdata_i;
                `XPU_REG_XIFS:      slv_reg9  <= reg_wdata_i;
                `XPU_REG_BB_RF_DLY: slv_reg10 <= reg_wdata_i;
                // read only and unmapped writes dropped
                default: ;
            endcase
        end
    end

    // rising edge of the load bit becomes a single clock pulse
    always_ff @(posedge s00_axi_aclk_i) begin
        if (reset_i) begin
            tsf_load_ctl_d <= 1'b0;
            tsf_load_pulse <= 1'b0;
        end else begin
            tsf_load_ctl_d <= slv_reg3[`XPU_BIT_TSF_LOAD];
            tsf_load_pulse <= slv_reg3[`XPU_BIT_TSF_LOAD] & ~tsf_load_ctl_d;
        end
    end

    // registered read port, one cycle latency
    always_ff @(posedge s00_axi_aclk_i) begin
        if (reset_i) begin
            reg_rdata_o <= '0;
        end else begin
            case (reg_rd_addr_i)
                `XPU_REG_RESET:     reg_rdata_o <= slv_reg0;
                `XPU_REG_MUTE:      reg_rdata_o <= slv_reg1;
                `XPU_REG_TSF_LO:    reg_rdata_o <= slv_reg2;
                `XPU_REG_TSF_HI:    reg_rdata_o <= slv_reg3;
                `XPU_REG_BAND:      reg_rdata_o <= slv_reg4;
                `XPU_REG_RSSI_TH:   reg_rdata_o <= slv_reg8;
                `XPU_REG_XIFS:      reg_rdata_o <= slv_reg9;
                `XPU_REG_BB_RF_DLY: reg_rdata_o <= slv_reg10;
                // live tsf halves
                `XPU_REG_TSF_RD_LO: reg_rdata_o <= tsf_runtime_val_i[31:0];
                `XPU_REG_TSF_RD_HI: reg_rdata_o <= tsf_runtime_val_i[63:32];
                `XPU_REG_VERSION:   reg_rdata_o <= `XPU_VERSION;
                default:            reg_rdata_o <= '0;
            endcase
        end
    end

    // load value, top bit of the high word is the trigger, not data
    assign cfg.tsf_load_pulse = tsf_load_pulse;
    assign cfg.tsf_load_val   = {1'b0, slv_reg3[`XPU_BIT_TSF_LOAD-1:0], slv_reg2};

    // band word fields
    assign band_o             = slv_reg4[`XPU_BAND_LSB +: 4];
    assign channel_o          = slv_reg4[7:0];
    assign cfg.band           = band_o;
    assign cfg.erp_short_slot = slv_reg4[`XPU_BIT_ERP_SHORT];

    // debug override of slot and sifs
    assign cfg.xifs_ovr = slv_reg9[`XPU_BIT_XIFS_OVR];
    assign cfg.slot_ovr = slv_reg9[`XPU_SLOT_LSB +: 5];
    assign cfg.sifs_ovr = slv_reg9[`XPU_SIFS_LSB +: 7];

    assign cfg.rssi_th  = slv_reg8[10:0];
    assign cfg.mute_ovr = slv_reg1[`XPU_BIT_MUTE_OVR];
    assign cfg.mute_val = slv_reg1[`XPU_BIT_MUTE_VAL];

    // plain fields to the tx-on detector
    assign txon_soft_rst_o   = slv_reg0[`XPU_BIT_RST_TXON];
    assign bb_rf_delay_top_o = slv_reg10[13:0];

endmodule

// File: logic/xpu_top.sv
// xpu lower mac timing core
`timescale 1ns/10ps

module xpu_top (
    input  logic                s00_axi_aclk_i,
    input  logic                reset_i,
    // register port
    input  logic                reg_wr_en_i,
    input  logic [5:0]          reg_addr_i,
    input  xpu_pkg::reg_word_t  reg_wdata_i,
    input  logic [5:0]          reg_rd_addr_i,
    output xpu_pkg::reg_word_t  reg_rdata_o,
    // from rx and cts-to-self
    input  xpu_pkg::rssi_t      rssi_half_db_i,
    input  logic                demod_is_ongoing_i,
    input  logic                cts_toself_rf_is_ongoing_i,
    // from phy tx
    input  logic                phy_tx_started_i,
    input  logic                phy_tx_done_i,
    // status out
    output xpu_pkg::tsf_t       tsf_runtime_val_o,
    output logic                tsf_pulse_1M_o,
    output logic                tx_bb_is_ongoing_o,
    output logic                tx_rf_is_ongoing_o,
    output logic                ch_idle_o,
    output logic                mute_adc_out_to_bb_o,
    output xpu_pkg::slot_t      slot_time_o,
    output xpu_pkg::sifs_t      sifs_time_o,
    output xpu_pkg::band_t      band_o,
    output xpu_pkg::channel_t   channel_o
);

    logic           txon_soft_rst;
    xpu_pkg::dly_t  bb_rf_delay_top;

    xpu_cfg_if cfg_if ();

    xpu_reg_bank xpu_reg_bank_i (
        .s00_axi_aclk_i    (s00_axi_aclk_i),
        .reset_i           (reset_i),
        .reg_wr_en_i       (reg_wr_en_i),
        .reg_addr_i        (reg_addr_i),
        .reg_wdata_i       (reg_wdata_i),
        .reg_rd_addr_i     (reg_rd_addr_i),
        .tsf_runtime_val_i (tsf_runtime_val_o),
        .reg_rdata_o       (reg_rdata_o),
        .cfg               (cfg_if.regs),
        .txon_soft_rst_o   (txon_soft_rst),
        .bb_rf_delay_top_o (bb_rf_delay_top),
        .band_o            (band_o),
        .channel_o         (channel_o)
    );

    tsf_timer tsf_timer_i (
        .s00_axi_aclk_i    (s00_axi_aclk_i),
        .reset_i           (reset_i),
        .cfg               (cfg_if.tsf),
        .tsf_runtime_val_o (tsf_runtime_val_o),
        .tsf_pulse_1M_o    (tsf_pulse_1M_o)
    );

    tx_on_detection tx_on_detection_i (
        .s00_axi_aclk_i     (s00_axi_aclk_i),
        .reset_i            (reset_i),
        .soft_rst_i         (txon_soft_rst),
        .bb_rf_delay_top_i  (bb_rf_delay_top),
        .phy_tx_started_i   (phy_tx_started_i),
        .phy_tx_done_i      (phy_tx_done_i),
        .tx_bb_is_ongoing_o (tx_bb_is_ongoing_o),
        .tx_rf_is_ongoing_o (tx_rf_is_ongoing_o)
    );

    medium_status medium_status_i (
        .cfg                        (cfg_if.status),
        .rssi_half_db_i             (rssi_half_db_i),
        .demod_is_ongoing_i         (demod_is_ongoing_i),
        .tx_rf_is_ongoing_i         (tx_rf_is_ongoing_o),
        .cts_toself_rf_is_ongoing_i (cts_toself_rf_is_ongoing_i),
        .ch_idle_o                  (ch_idle_o),
        .mute_adc_out_to_bb_o       (mute_adc_out_to_bb_o),
        .slot_time_o                (slot_time_o),
        .sifs_time_o                (sifs_time_o)
    );

endmodule

// File: src.f
+incdir+common
common/xpu_pkg.sv
common/xpu_cfg_if.sv
logic/xpu_reg_bank.sv
tsf/tsf_timer.sv
tx_on/tx_on_detection.sv
logic/medium_status.sv
logic/xpu_top.sv
verif/xpu_properties.sv
verif/xpu_checker.sv
verif/xpu_tb.sv

// File: tsf/tsf_timer.sv
// 64-bit tsf timer
`timescale 1ns/10ps
`include "xpu_macros.svh"

module tsf_timer (
    input  logic            s00_axi_aclk_i,
    input  logic            reset_i,
    xpu_cfg_if.tsf          cfg,
    output xpu_pkg::tsf_t   tsf_runtime_val_o,
    output logic            tsf_pulse_1M_o
);

    localparam int DIV_W = $clog2(`XPU_CLK_PER_US);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`XPU_CLK_PER_US - 1);

    logic [DIV_W-1:0] div_cnt;

    // 1MHz tick on the last divider count
    assign tsf_pulse_1M_o = (div_cnt == DIV_LAST);

    // microsecond divider
    always_ff @(posedge s00_axi_aclk_i) begin
        if (reset_i) begin
            div_cnt <= '0;
        end else if (cfg.tsf_load_pulse) begin
            // restart so the first tick is a full us after load
            div_cnt <= '0;
        end else if (tsf_pulse_1M_o) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // tsf counter, load beats the tick
    always_ff @(posedge s00_axi_aclk_i) begin
        if (reset_i) begin
            tsf_runtime_val_o <= '0;
        end else if (cfg.tsf_load_pulse) begin
            tsf_runtime_val_o <= cfg.tsf_load_val;
        end else if (tsf_pulse_1M_o) begin
            tsf_runtime_val_o <= tsf_runtime_val_o + 64'd1;
        end
    end

endmodule

// File: tx_on/tx_on_detection.sv
// baseband and rf transmit window tracker
`timescale 1ns/10ps

module tx_on_detection (
    input  logic            s00_axi_aclk_i,
    input  logic            reset_i,
    input  logic            soft_rst_i,
    input  xpu_pkg::dly_t   bb_rf_delay_top_i,
    input  logic            phy_tx_started_i,
    input  logic            phy_tx_done_i,
    output logic            tx_bb_is_ongoing_o,
    output logic            tx_rf_is_ongoing_o
);

    xpu_pkg::txon_state_t   state;
    xpu_pkg::dly_t          tail_cnt;
    logic [14:0]            tail_cnt_inc;
    logic                   tail_done;

    // one extra bit so the compare never wraps
    assign tail_cnt_inc = {1'b0, tail_cnt} + 15'd1;
    // top may shrink mid tail, so compare with >=
    assign tail_done    = (tail_cnt_inc >= {1'b0, bb_rf_delay_top_i});

    always_ff @(posedge s00_axi_aclk_i) begin
        if (reset_i || soft_rst_i) begin
            state    <= xpu_pkg::TXON_IDLE;
            tail_cnt <= '0;
        end else begin
            case (state)
                xpu_pkg::TXON_IDLE: begin
                    if (phy_tx_started_i) begin
                        state <= xpu_pkg::TXON_BB;
                    end
                end
                xpu_pkg::TXON_BB: begin
                    if (phy_tx_done_i) begin
                        tail_cnt <= '0;
                        // zero delay skips the rf tail
                        if (bb_rf_delay_top_i == '0) begin
                            state <= xpu_pkg::TXON_IDLE;
                        end else begin
                            state <= xpu_pkg::TXON_RF_TAIL;
                        end
                    end
                end
                xpu_pkg::TXON_RF_TAIL: begin
                    // back to back packet while rf still on
                    if (phy_tx_started_i) begin
                        state <= xpu_pkg::TXON_BB;
                    end else if (tail_done) begin
                        state <= xpu_pkg::TXON_IDLE;
                    end else begin
                        tail_cnt <= tail_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= xpu_pkg::TXON_IDLE;
                end
            endcase
        end
    end

    // outputs straight from state
    assign tx_bb_is_ongoing_o = (state == xpu_pkg::TXON_BB);
    // rf covers bb plus the tail
    assign tx_rf_is_ongoing_o = (state != xpu_pkg::TXON_IDLE);

endmodule

// File: verif/xpu_checker.sv
// xpu reference model and compare
`timescale 1ns/10ps
`include "xpu_macros.svh"

module xpu_checker (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                reg_wr_en_i,
    input  logic [5:0]          reg_addr_i,
    input  xpu_pkg::reg_word_t  reg_wdata_i,
    input  logic [5:0]          reg_rd_addr_i,
    input  xpu_pkg::rssi_t      rssi_half_db_i,
    input  logic                demod_is_ongoing_i,
    input  logic                cts_toself_rf_is_ongoing_i,
    input  logic                phy_tx_started_i,
    input  logic                phy_tx_done_i,
    input  xpu_pkg::reg_word_t  reg_rdata_i,
    input  xpu_pkg::tsf_t       tsf_runtime_val_i,
    input  logic                tsf_pulse_1M_i,
    input  logic                tx_bb_is_ongoing_i,
    input  logic                tx_rf_is_ongoing_i,
    input  logic                ch_idle_i,
    input  logic                mute_adc_out_to_bb_i,
    input  xpu_pkg::slot_t      slot_time_i,
    input  xpu_pkg::sifs_t      sifs_time_i,
    input  xpu_pkg::band_t      band_i,
    input  xpu_pkg::channel_t   channel_i,
    output int                  err_cnt_o
);

    // model state, all values as seen during the cycle just ended
    xpu_pkg::reg_word_t regs [0:63];
    xpu_pkg::reg_word_t rdata;
    xpu_pkg::tsf_t      tsf;
    int                 div;
    logic               load_d;
    logic               load_pulse;
    logic               bb;
    int                 tail_left;
    logic               model_valid = 1'b0;
    int                 err_cnt = 0;

    assign err_cnt_o = err_cnt;

    function automatic logic is_writable(input logic [5:0] addr);
        case (addr)
            `XPU_REG_RESET, `XPU_REG_MUTE, `XPU_REG_TSF_LO, `XPU_REG_TSF_HI,
            `XPU_REG_BAND, `XPU_REG_RSSI_TH, `XPU_REG_XIFS, `XPU_REG_BB_RF_DLY:
                return 1'b1;
            default:
                return 1'b0;
        endcase
    endfunction

    // register map as a reader sees it
    function automatic xpu_pkg::reg_word_t read_value(input logic [5:0] addr);
        if (is_writable(addr))
            return regs[addr];
        case (addr)
            `XPU_REG_TSF_RD_LO: return tsf[31:0];
            `XPU_REG_TSF_RD_HI: return tsf[63:32];
            `XPU_REG_VERSION:   return `XPU_VERSION;
            default:            return '0;
        endcase
    endfunction

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %0h expected %0h at %0t", name, got, exp, $time);
            err_cnt++;
        end
    endtask

    always @(posedge clk_i) begin : model_step
        logic               rf_m;
        logic               own_rf;
        logic               is_24g;
        xpu_pkg::slot_t     slot_m;
        xpu_pkg::sifs_t     sifs_m;
        if (reset_i) begin
            for (int a = 0; a < 64; a++)
                regs[a] = '0;
            rdata       = '0;
            tsf         = '0;
            div         = 0;
            load_d      = 1'b0;
            load_pulse  = 1'b0;
            bb          = 1'b0;
            tail_left   = 0;
            model_valid = 1'b1;
        end else if (model_valid) begin
            // rf covers bb and the tail after it
            rf_m   = bb || (tail_left > 0);
            own_rf = rf_m || cts_toself_rf_is_ongoing_i;
            // band defaults, override from reg 9 bit 31
            is_24g = (regs[4][`XPU_BAND_LSB +: 4] == `XPU_BAND_24G);
            if (regs[9][`XPU_BIT_XIFS_OVR]) begin
                slot_m = regs[9][`XPU_SLOT_LSB +: 5];
                sifs_m = regs[9][`XPU_SIFS_LSB +: 7];
            end else if (is_24g) begin
                slot_m = regs[4][`XPU_BIT_ERP_SHORT] ? 5'd9 : 5'd20;
                sifs_m = 7'd10;
            end else begin
                slot_m = 5'd9;
                sifs_m = 7'd16;
            end
            compare("reg_rdata_o", reg_rdata_i, rdata);
            compare("tsf_runtime_val_o", tsf_runtime_val_i, tsf);
            compare("tsf_pulse_1M_o", tsf_pulse_1M_i, div == `XPU_CLK_PER_US - 1);
            compare("tx_bb_is_ongoing_o", tx_bb_is_ongoing_i, bb);
            compare("tx_rf_is_ongoing_o", tx_rf_is_ongoing_i, rf_m);
            compare("ch_idle_o", ch_idle_i,
                ($signed(rssi_half_db_i) < $signed(regs[8][10:0]))
                && !demod_is_ongoing_i && !own_rf);
            compare("mute_adc_out_to_bb_o", mute_adc_out_to_bb_i,
                regs[1][`XPU_BIT_MUTE_OVR] ? regs[1][`XPU_BIT_MUTE_VAL] : own_rf);
            compare("slot_time_o", slot_time_i, slot_m);
            compare("sifs_time_o", sifs_time_i, sifs_m);
            compare("band_o", band_i, regs[4][`XPU_BAND_LSB +: 4]);
            compare("channel_o", channel_i, regs[4][7:0]);

            // read data from the state before this edge
            rdata = read_value(reg_rd_addr_i);
            // tsf, load beats the tick and restarts the us count
            if (load_pulse) begin
                tsf = {1'b0, regs[3][30:0], regs[2]};
                div = 0;
            end else if (div == `XPU_CLK_PER_US - 1) begin
                tsf = tsf + 64'd1;
                div = 0;
            end else begin
                div = div + 1;
            end
            // load request on a rising bit 31
            load_pulse = regs[3][`XPU_BIT_TSF_LOAD] && !load_d;
            load_d     = regs[3][`XPU_BIT_TSF_LOAD];
            // tx windows
            if (regs[0][`XPU_BIT_RST_TXON]) begin
                bb        = 1'b0;
                tail_left = 0;
            end else if (bb) begin
                if (phy_tx_done_i) begin
                    bb        = 1'b0;
                    tail_left = int'(regs[10][13:0]);
                end
            end else if (phy_tx_started_i) begin
                bb = 1'b1;
            end else if (tail_left > 0) begin
                tail_left = tail_left - 1;
            end
            // write lands last
            if (reg_wr_en_i && is_writable(reg_addr_i))
                regs[reg_addr_i] = reg_wdata_i;
        end
    end

endmodule

// File: verif/xpu_properties.sv
// tx-on and tsf pulse assertions
`timescale 1ns/10ps

module xpu_properties (
    input  logic    clk_i,
    input  logic    reset_i,
    input  logic    soft_rst_i,
    input  logic    phy_tx_done_i,
    input  logic    tx_bb_i,
    input  logic    tx_rf_i,
    input  logic    tsf_pulse_i
);

    // rf window always covers the bb window
    rf_covers_bb: assert property (@(posedge clk_i) disable iff (reset_i)
        tx_bb_i |-> tx_rf_i)
        else $error("rf ongoing low while bb ongoing high");

    // bb drops only after a done strobe, or when held by soft reset
    bb_falls_after_done: assert property (@(posedge clk_i) disable iff (reset_i)
        $fell(tx_bb_i) |-> ($past(phy_tx_done_i) || $past(soft_rst_i)))
        else $error("bb ongoing fell without a done strobe the cycle before");

    // 1MHz tick is a single clock wide
    pulse_one_clock: assert property (@(posedge clk_i) disable iff (reset_i)
        tsf_pulse_i |=> !tsf_pulse_i)
        else $error("tsf pulse high on two consecutive clocks");

endmodule

// File: verif/xpu_tb.sv
// xpu testbench top
`timescale 1ns/10ps
`include "xpu_macros.svh"

module xpu_tb;

    logic                   clk = 1'b0;
    logic                   reset_i;
    logic                   reg_wr_en_i;
    logic [5:0]             reg_addr_i;
    xpu_pkg::reg_word_t     reg_wdata_i;
    logic [5:0]             reg_rd_addr_i;
    xpu_pkg::rssi_t         rssi_half_db_i;
    logic                   demod_is_ongoing_i;
    logic                   cts_toself_rf_is_ongoing_i;
    logic                   phy_tx_started_i;
    logic                   phy_tx_done_i;
    xpu_pkg::reg_word_t     reg_rdata_o;
    xpu_pkg::tsf_t          tsf_runtime_val_o;
    logic                   tsf_pulse_1M_o;
    logic                   tx_bb_is_ongoing_o;
    logic                   tx_rf_is_ongoing_o;
    logic                   ch_idle_o;
    logic                   mute_adc_out_to_bb_o;
    xpu_pkg::slot_t         slot_time_o;
    xpu_pkg::sifs_t         sifs_time_o;
    xpu_pkg::band_t         band_o;
    xpu_pkg::channel_t      channel_o;

    int                     seed = 74;
    int                     rd_pin = -1;
    int                     tb_errors = 0;
    int                     err_cnt;
    int                     err_mark = 0;
    int                     wait_cycles;
    xpu_pkg::tsf_t          tsf_target;

    // 4 ns clock
    always #2 clk = ~clk;

    xpu_top dut_i (.*, .s00_axi_aclk_i(clk));

    xpu_checker checker_i (.*, .clk_i(clk), .reg_rdata_i(reg_rdata_o),
        .tsf_runtime_val_i(tsf_runtime_val_o), .tsf_pulse_1M_i(tsf_pulse_1M_o),
        .tx_bb_is_ongoing_i(tx_bb_is_ongoing_o), .tx_rf_is_ongoing_i(tx_rf_is_ongoing_o),
        .ch_idle_i(ch_idle_o), .mute_adc_out_to_bb_i(mute_adc_out_to_bb_o),
        .slot_time_i(slot_time_o), .sifs_time_i(sifs_time_o), .band_i(band_o),
        .channel_i(channel_o), .err_cnt_o(err_cnt));

    bind xpu_top xpu_properties props_i (.clk_i(s00_axi_aclk_i), .reset_i(reset_i),
        .soft_rst_i(txon_soft_rst), .phy_tx_done_i(phy_tx_done_i),
        .tx_bb_i(tx_bb_is_ongoing_o), .tx_rf_i(tx_rf_is_ongoing_o),
        .tsf_pulse_i(tsf_pulse_1M_o));

    // random rx side activity and read addresses every clock
    always @(posedge clk) begin : medium_noise
        logic [31:0] r;
        if (!reset_i) begin
            r = $random(seed);
            rssi_half_db_i             <= r[10:0];
            demod_is_ongoing_i         <= (r[13:12] == 2'b00);
            cts_toself_rf_is_ongoing_i <= (r[16:14] == 3'b000);
            // pinned address, last write address or a random one
            if (rd_pin >= 0)
                reg_rd_addr_i <= rd_pin[5:0];
            else if (r[20])
                reg_rd_addr_i <= reg_addr_i;
            else
                reg_rd_addr_i <= r[29:24];
        end
    end

    task automatic write_reg(input logic [5:0] addr, input xpu_pkg::reg_word_t data);
        @(posedge clk);
        reg_wr_en_i <= 1'b1;
        reg_addr_i  <= addr;
        reg_wdata_i <= data;
        @(posedge clk);
        reg_wr_en_i <= 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic strobe_phy(input logic is_done);
        @(posedge clk);
        if (is_done)
            phy_tx_done_i <= 1'b1;
        else
            phy_tx_started_i <= 1'b1;
        @(posedge clk);
        phy_tx_started_i <= 1'b0;
        phy_tx_done_i    <= 1'b0;
    endtask

    // which selects bb, rf, tsf pulse or tsf against target in that order
    // sampled mid cycle
    task automatic wait_for(input string what, input int which, input logic level,
                            input int limit);
        logic seen;
        seen        = 1'b0;
        wait_cycles = 0;
        while (!seen && wait_cycles < limit) begin
            @(negedge clk);
            wait_cycles++;
            case (which)
                0: seen = (tx_bb_is_ongoing_o === level);
                1: seen = (tx_rf_is_ongoing_o === level);
                2: seen = (tsf_pulse_1M_o === level);
                default: seen = (tsf_runtime_val_o === tsf_target);
            endcase
        end
        if (!seen) begin
            $display("timeout after %0d cycles waiting for %s", limit, what);
            tb_errors++;
        end
    endtask

    task automatic finish_step(input string name);
        @(negedge clk);
        $display("%s: %0d errors", name, err_cnt + tb_errors - err_mark);
        err_mark = err_cnt + tb_errors;
    endtask

    initial begin : main
        xpu_pkg::reg_word_t w;
        xpu_pkg::reg_word_t lo;
        int top;
        reset_i                    = 1'b1;
        reg_wr_en_i                = 1'b0;
        reg_addr_i                 = '0;
        reg_wdata_i                = '0;
        reg_rd_addr_i              = '0;
        rssi_half_db_i             = '0;
        demod_is_ongoing_i         = 1'b0;
        cts_toself_rf_is_ongoing_i = 1'b0;
        phy_tx_started_i           = 1'b0;
        phy_tx_done_i              = 1'b0;
        repeat (8) @(posedge clk);
        reset_i <= 1'b0;

        // register map, random writes everywhere
        for (int i = 0; i < 200; i++) begin
            w = $random(seed);
            write_reg(w[5:0], $random(seed));
        end
        rd_pin <= `XPU_REG_VERSION;
        idle_cycles(3);
        rd_pin <= -1;
        write_reg(`XPU_REG_RESET, '0);
        finish_step("register write and readback");

        // pulse spacing then a load on a rising bit 31
        wait_for("first tsf pulse", 2, 1'b1, 2 * `XPU_CLK_PER_US);
        wait_for("second tsf pulse", 2, 1'b1, 2 * `XPU_CLK_PER_US);
        if (wait_cycles != `XPU_CLK_PER_US) begin
            $display("tsf pulses came %0d clocks apart", wait_cycles);
            tb_errors++;
        end
        lo = $random(seed);
        w  = $random(seed);
        w  = w | 32'h8010_0000;
        write_reg(`XPU_REG_TSF_HI, w & 32'h7fff_ffff);
        write_reg(`XPU_REG_TSF_LO, lo);
        write_reg(`XPU_REG_TSF_HI, w);
        tsf_target = {1'b0, w[30:0], lo};
        wait_for("tsf load value", 3, 1'b1, 10);
        // loaded value shows one clock after the load pulse
        wait_for("tsf pulse after load", 2, 1'b1, 2 * `XPU_CLK_PER_US);
        if (wait_cycles != `XPU_CLK_PER_US - 1) begin
            $display("first pulse after load came %0d clocks late", wait_cycles);
            tb_errors++;
        end
        rd_pin <= `XPU_REG_TSF_RD_LO;
        idle_cycles(4);
        rd_pin <= `XPU_REG_TSF_RD_HI;
        idle_cycles(4);
        rd_pin <= -1;
        finish_step("tsf count and load");

        // start and done pairs with every fourth tail at zero
        for (int i = 0; i < 24; i++) begin
            w   = $random(seed);
            top = (i % 4 == 0) ? 0 : int'(w[4:0]) + 1;
            write_reg(`XPU_REG_BB_RF_DLY, top);
            strobe_phy(1'b0);
            wait_for("bb ongoing high", 0, 1'b1, 10);
            idle_cycles(int'(w[11:8]) + 1);
            strobe_phy(1'b1);
            wait_for("rf ongoing low", 1, 1'b0, top + 10);
        end
        write_reg(`XPU_REG_RESET, 32'h1);
        strobe_phy(1'b0);
        idle_cycles(6);
        @(negedge clk);
        if (tx_bb_is_ongoing_o || tx_rf_is_ongoing_o) begin
            $display("tx flags went high while the tx-on soft reset was set");
            tb_errors++;
        end
        write_reg(`XPU_REG_RESET, '0);
        finish_step("transmit windows");

        // threshold against random rssi from the noise block
        for (int i = 0; i < 40; i++) begin
            write_reg(`XPU_REG_RSSI_TH, $random(seed));
            idle_cycles(4);
        end
        finish_step("channel idle");

        for (int i = 0; i < 16; i++) begin
            write_reg(`XPU_REG_MUTE, $random(seed));
            idle_cycles(4);
        end
        finish_step("adc mute");

        // every band code with erp short slot off and on
        write_reg(`XPU_REG_XIFS, '0);
        for (int i = 0; i < 32; i++) begin
            w = $random(seed);
            w[`XPU_BAND_LSB +: 4]   = i[3:0];
            w[`XPU_BIT_ERP_SHORT]   = i[4];
            write_reg(`XPU_REG_BAND, w);
            idle_cycles(2);
        end
        for (int i = 0; i < 8; i++) begin
            w = $random(seed);
            w[`XPU_BIT_XIFS_OVR] = ~i[0];
            write_reg(`XPU_REG_XIFS, w);
            idle_cycles(2);
        end
        finish_step("slot and sifs selection");

        idle_cycles(2);
        @(negedge clk);
        $display("closing count: %0d failed checks over 6 tests", err_cnt + tb_errors);
        if (err_cnt + tb_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
